//--- verilog/env_gen_macros.svh
// **************************************************
// envelope generator sizing and fixed-point layout
// shared by the packages and the RTL
// **************************************************
`ifndef ENV_GEN_MACROS_SVH
`define ENV_GEN_MACROS_SVH

`define ENV_VOICES          8       // voices served
`define ENV_ENVS            8       // envelopes per voice

// step numerator is (target - start) << this
`define ENV_NUM_SHIFT       22

`define ENV_LEVEL_MSB       36      // accumulator bits that form the output level
`define ENV_LEVEL_LSB       29

`define ENV_MAINVOL         1       // envelope driving voice_free

`define ENV_SUSTAIN_DEFAULT 8'h7f   // level 3 after reset, envelopes 0..2

`endif

//--- verilog/env_regmap_pkg.sv
// **************************************************
// envelope register map types
// rate and level bytes, bus address and data
// **************************************************
package env_regmap_pkg;

    typedef logic [7:0] env_rate_t;         // 0 jumps straight to target
    typedef logic signed [7:0] env_lvl_t;

    // {0, env[2:0], level/rate, index[1:0]}
    typedef logic [6:0] env_addr_t;

    typedef logic [7:0] env_data_t;

    // index 0..3 is rate/level 1..4, level 3 sits at lvl[2]
    typedef struct packed {
        env_lvl_t  [3:0] lvl;
        env_rate_t [3:0] rate;
    } env_params_t;

endpackage

//--- verilog/env_state_pkg.sv
// **************************************************
// envelope state types
// slot index, FSM states and the stored slot record
// **************************************************
`include "env_gen_macros.svh"

package env_state_pkg;

    typedef logic [$clog2(`ENV_VOICES)-1:0] voice_idx_t;
    typedef logic [$clog2(`ENV_ENVS)-1:0] env_idx_t;

    typedef struct packed {
        voice_idx_t voice;
        env_idx_t   env;
    } slot_t;

    // order matters, each LEVELn follows its RATEn
    typedef enum logic [3:0] {
        IDLE,
        RATE1,
        LEVEL1,
        RATE2,
        LEVEL2,
        RATE3,
        LEVEL3,
        RATE4,
        LEVEL4
    } env_state_e;

    typedef logic signed [`ENV_LEVEL_MSB:0] acc_t;  // level with fraction bits
    typedef logic [15:0] denom_t;                   // rate squared

    typedef struct packed {
        denom_t                   denom;
        acc_t                     numer;
        acc_t                     level;
        env_regmap_pkg::env_lvl_t start;  // level when segment began
        env_state_e               state;
    } slot_rec_t;

endpackage

//--- verilog/env_param_regs.sv
// **************************************************
// envelope parameter registers
// bus-mapped rates and levels, lookup per envelope
// **************************************************
`timescale 1ns/1ps
`include "env_gen_macros.svh"

module env_param_regs (
    input  logic                        read,
    input  logic                        reset_reg_N,
    input  env_regmap_pkg::env_addr_t   addr,
    input  env_regmap_pkg::env_data_t   wr_data,
    input  logic                        wr_en,
    input  logic                        rd_en,
    output env_regmap_pkg::env_data_t   rd_data,
    input  env_state_pkg::env_idx_t     param_env,
    output env_regmap_pkg::env_params_t params
);
    import env_regmap_pkg::*;
    import env_state_pkg::*;

    env_params_t regs [`ENV_ENVS];

    logic       hit;
    env_idx_t   a_env;
    logic       a_is_lvl;
    logic [1:0] a_idx;

    assign hit      = !addr[6];     // upper half of the map is empty
    assign a_env    = addr[5:3];
    assign a_is_lvl = addr[2];
    assign a_idx    = addr[1:0];

    always_ff @(posedge read or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            for (int e = 0; e < `ENV_ENVS; e++) begin
                regs[e] <= '0;
                if (e <= 2) begin
                    regs[e].lvl[2] <= `ENV_SUSTAIN_DEFAULT;
                end
            end
            rd_data <= '0;
        end else begin
            if (wr_en && hit) begin
                if (a_is_lvl) begin
                    regs[a_env].lvl[a_idx] <= wr_data;
                end else begin
                    regs[a_env].rate[a_idx] <= wr_data;
                end
            end
            if (rd_en) begin
                if (!hit) begin
                    rd_data <= '0;
                end else if (a_is_lvl) begin
                    rd_data <= regs[a_env].lvl[a_idx];
                end else begin
                    rd_data <= regs[a_env].rate[a_idx];
                end
            end
        end
    end

    assign params = regs[param_env];    // combinational lookup for the core

    a_bus_excl: assert property (@(posedge read) disable iff (!reset_reg_N)
        !(wr_en && rd_en))
        else $error("wr_en and rd_en high together");

endmodule

//--- verilog/env_state_ram.sv
// **************************************************
// slot state memory
// one record per voice/envelope slot
// **************************************************
`timescale 1ns/1ps
`include "env_gen_macros.svh"

module env_state_ram (
    input  logic                     read,
    input  env_state_pkg::slot_t     rd_slot,
    output env_state_pkg::slot_rec_t rd_rec,
    input  env_state_pkg::slot_t     wr_slot,
    input  env_state_pkg::slot_rec_t wr_rec,
    input  logic                     wr_en
);
    import env_state_pkg::*;

    slot_rec_t mem [`ENV_VOICES * `ENV_ENVS];

    // cleared by the core's sweep after reset
    always_ff @(posedge read) begin
        if (wr_en) begin
            mem[wr_slot] <= wr_rec;
        end
    end

    // read during write of the same slot returns the old record
    always_ff @(posedge read) begin
        rd_rec <= mem[rd_slot];
    end

endmodule

//--- verilog/env_core.sv
// **************************************************
// envelope core
// init sweep, 2-stage slot pipeline, step divider, FSM
// **************************************************
`timescale 1ns/1ps
`include "env_gen_macros.svh"

module env_core (
    input  logic                        read,
    input  logic                        reset_reg_N,
    input  env_state_pkg::slot_t        slot_sel,
    input  logic [`ENV_VOICES-1:0]      keys_on,
    output env_state_pkg::env_idx_t     param_env,
    input  env_regmap_pkg::env_params_t params,
    output env_state_pkg::slot_t        rd_slot,
    input  env_state_pkg::slot_rec_t    rd_rec,
    output env_state_pkg::slot_t        wr_slot,
    output env_state_pkg::slot_rec_t    wr_rec,
    output logic                        wr_en,
    output env_regmap_pkg::env_lvl_t    level_out,
    output logic [`ENV_VOICES-1:0]      voice_free,
    output logic                        init_busy
);
    import env_regmap_pkg::*;
    import env_state_pkg::*;

    localparam int slot_w = $bits(slot_t);
    localparam slot_rec_t idle_rec = '{denom: denom_t'(1), numer: '0, level: '0,
                                       start: '0, state: IDLE};

    function automatic acc_t mk_numer(env_lvl_t tgt, env_lvl_t from);
        logic signed [8:0] diff;
        acc_t ext;
        diff = tgt - from;
        ext = diff;
        return ext <<< `ENV_NUM_SHIFT;
    endfunction

    function automatic denom_t mk_denom(env_rate_t rt);
        denom_t r16;
        r16 = rt;
        return (rt == '0) ? denom_t'(1) : r16 * r16;   // never 0
    endfunction

    function automatic acc_t lvl_to_acc(env_lvl_t lv);
        acc_t ext;
        ext = lv;
        return ext <<< `ENV_LEVEL_LSB;
    endfunction

    // new segment from the current level toward tgt
    function automatic slot_rec_t begin_seg(slot_rec_t r, env_lvl_t tgt, env_rate_t rt,
                                            env_state_e st);
        slot_rec_t o;
        o = r;
        o.start = r.level[`ENV_LEVEL_MSB:`ENV_LEVEL_LSB];
        o.numer = mk_numer(tgt, o.start);
        o.denom = mk_denom(rt);
        o.state = st;
        return o;
    endfunction

    logic [slot_w-1:0] init_cnt;
    slot_t             s1_slot, s2_slot;
    env_params_t       s1_params;
    logic              s1_valid, s2_valid;
    slot_rec_t         s2_rec, nxt;
    logic signed [16:0] den_s;
    acc_t              quotient, stepped;
    env_lvl_t          nxt_top, tgt, nxt_tgt;
    env_rate_t         seg_rate, nxt_rate;
    logic [3:0]        st_m1;
    logic [1:0]        seg;
    logic              key, reached, step_taken, free_nxt;

    assign rd_slot   = slot_sel;
    assign param_env = slot_sel.env;

    assign den_s    = {1'b0, rd_rec.denom};
    assign quotient = rd_rec.numer / den_s;
    assign stepped  = rd_rec.level + quotient;
    assign nxt_top  = stepped[`ENV_LEVEL_MSB:`ENV_LEVEL_LSB];
    assign key      = keys_on[s1_slot.voice];

    // RATEn and LEVELn both map to segment n-1
    assign st_m1    = rd_rec.state - 4'd1;
    assign seg      = st_m1[2:1];
    assign tgt      = s1_params.lvl[seg];
    assign seg_rate = s1_params.rate[seg];
    assign nxt_tgt  = s1_params.lvl[seg + 2'd1];    // segment 4 wraps to 1
    assign nxt_rate = s1_params.rate[seg + 2'd1];
    assign reached  = (quotient < 0) ? (nxt_top <= tgt) : (nxt_top >= tgt);

    always_comb begin
        nxt = rd_rec;
        step_taken = 1'b0;
        case (rd_rec.state)
            IDLE: begin
                nxt = idle_rec;
                if (key) begin
                    nxt = begin_seg(idle_rec, s1_params.lvl[0], s1_params.rate[0], RATE1);
                end
            end
            RATE1, RATE2, RATE3, RATE4: begin
                if (rd_rec.state == RATE4 && key) begin
                    nxt = begin_seg(rd_rec, nxt_tgt, nxt_rate, RATE1);    // retrigger
                end else if (rd_rec.state != RATE4 && !key) begin
                    nxt = begin_seg(rd_rec, s1_params.lvl[3], s1_params.rate[3], RATE4);
                end else if (seg_rate != '0 && !reached) begin
                    step_taken = 1'b1;
                    nxt.level = stepped;
                end else begin
                    nxt.level = lvl_to_acc(tgt);
                    nxt.state = env_state_e'(rd_rec.state + 4'd1);
                end
            end
            LEVEL1, LEVEL2: begin
                if (!key) begin
                    nxt = begin_seg(rd_rec, s1_params.lvl[3], s1_params.rate[3], RATE4);
                end else begin
                    nxt = begin_seg(rd_rec, nxt_tgt, nxt_rate,
                                    env_state_e'(rd_rec.state + 4'd1));
                end
            end
            LEVEL3: begin
                if (!key) begin
                    nxt = begin_seg(rd_rec, s1_params.lvl[3], s1_params.rate[3], RATE4);
                end else begin
                    nxt.level = lvl_to_acc(tgt);    // sustain
                end
            end
            LEVEL4: begin
                if (tgt == '0) begin
                    nxt = idle_rec;
                end else if (key) begin
                    nxt = begin_seg(rd_rec, nxt_tgt, nxt_rate, RATE1);
                end else begin
                    nxt.level = lvl_to_acc(tgt);
                end
            end
            default: nxt = idle_rec;
        endcase
    end

    assign free_nxt = (nxt.state == IDLE) || (nxt.state == LEVEL4);

    always_ff @(posedge read or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            init_cnt   <= '0;
            init_busy  <= 1'b1;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            level_out  <= '0;
            voice_free <= '1;
        end else begin
            if (init_busy) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == slot_w'(`ENV_VOICES * `ENV_ENVS - 1)) begin
                    init_busy <= 1'b0;
                end
            end
            s1_valid <= !init_busy;     // slot inputs ignored during sweep
            s2_valid <= s1_valid;
            if (s1_valid) begin
                level_out <= nxt.level[`ENV_LEVEL_MSB:`ENV_LEVEL_LSB];
                if (s1_slot.env == `ENV_MAINVOL) begin
                    voice_free[s1_slot.voice] <= free_nxt;
                end
            end
        end
    end

    always_ff @(posedge read) begin
        s1_slot   <= slot_sel;
        s1_params <= params;
        s2_slot   <= s1_slot;
        s2_rec    <= nxt;
    end

    assign wr_en   = init_busy | s2_valid;
    assign wr_slot = init_busy ? slot_t'(init_cnt) : s2_slot;
    assign wr_rec  = init_busy ? idle_rec : s2_rec;

    // record read back from the memory must hold a defined state
    a_state_legal: assert property (@(posedge read) disable iff (!reset_reg_N)
        s1_valid |-> (rd_rec.state <= LEVEL4))
        else $error("illegal envelope state read back");

    a_denom_nonzero: assert property (@(posedge read) disable iff (!reset_reg_N)
        (s1_valid && step_taken) |-> (rd_rec.denom != '0))
        else $error("step taken with zero denominator");

endmodule

//--- verilog/env_gen_top.sv
// **************************************************
// envelope generator top
// register file, slot state memory and core
// **************************************************
`timescale 1ns/1ps
`include "env_gen_macros.svh"

module env_gen_top (
    input  logic                      read,
    input  logic                      reset_reg_N,
    input  env_regmap_pkg::env_addr_t addr,
    input  env_regmap_pkg::env_data_t wr_data,
    input  logic                      wr_en,
    input  logic                      rd_en,
    output env_regmap_pkg::env_data_t rd_data,
    input  env_state_pkg::slot_t      slot_sel,
    input  logic [`ENV_VOICES-1:0]    keys_on,
    output env_regmap_pkg::env_lvl_t  level_out,
    output logic [`ENV_VOICES-1:0]    voice_free,
    output logic                      init_busy
);
    import env_regmap_pkg::*;
    import env_state_pkg::*;

    env_idx_t    param_env;
    env_params_t params;
    slot_t       rd_slot, wr_slot;
    slot_rec_t   rd_rec, wr_rec;
    logic        ram_wr_en;

    env_param_regs regs_i (
        .read        (read),
        .reset_reg_N (reset_reg_N),
        .addr        (addr),
        .wr_data     (wr_data),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .param_env   (param_env),
        .params      (params)
    );

    env_state_ram ram_i (
        .read    (read),
        .rd_slot (rd_slot),
        .rd_rec  (rd_rec),
        .wr_slot (wr_slot),
        .wr_rec  (wr_rec),
        .wr_en   (ram_wr_en)
    );

    env_core core_i (
        .read        (read),
        .reset_reg_N (reset_reg_N),
        .slot_sel    (slot_sel),
        .keys_on     (keys_on),
        .param_env   (param_env),
        .params      (params),
        .rd_slot     (rd_slot),
        .rd_rec      (rd_rec),
        .wr_slot     (wr_slot),
        .wr_rec      (wr_rec),
        .wr_en       (ram_wr_en),
        .level_out   (level_out),
        .voice_free  (voice_free),
        .init_busy   (init_busy)
    );

endmodule

//--- tests/env_gen_tb.sv
// **************************************************
// envelope generator testbench
// register read-back, init sweep, instant and stepped
// envelopes, release and voice_free on a slot scan
// **************************************************
`timescale 1ns/1ps
`include "env_gen_macros.svh"

module env_gen_tb;
    import env_regmap_pkg::*;
    import env_state_pkg::*;

    localparam int max_cycles = 64 + 40 * 64 + 200;   // sweep, scan rounds, margin
    localparam env_lvl_t att_l1 = 8'sh60;             // level 1 of the stepped envelope
    localparam env_lvl_t sus_lvl = 8'sh20;            // level 3 of the instant envelopes

    logic                   read;
    logic                   reset_reg_N;
    env_addr_t              addr;
    env_data_t              wr_data;
    logic                   wr_en;
    logic                   rd_en;
    env_data_t              rd_data;
    slot_t                  slot_sel;
    logic [`ENV_VOICES-1:0] keys_on;
    env_lvl_t               level_out;
    logic [`ENV_VOICES-1:0] voice_free;
    logic                   init_busy;

    logic [15:0] lfsr_state = 16'd80;
    logic [5:0]  scan_cnt = '0;
    int          cycle_cnt = 0;
    int          busy_cycles = 0;
    logic        busy_d = 1'b0;
    env_data_t   shadow [128];
    env_data_t   rd_exp = '0;
    slot_t       slot_d1 = '0;
    slot_t       slot_d2 = '0;
    logic        v_d1 = 1'b0;
    logic        v_d2 = 1'b0;
    logic [`ENV_VOICES-1:0] key_d2 = '0;
    logic [7:0]  held_cnt [`ENV_ENVS];  // voice 0 outputs with key held, per envelope
    logic [7:0]  rel_cnt [`ENV_ENVS];   // voice 0 outputs after release
    env_lvl_t    att_prev = '0;
    logic        out_v0;

    env_gen_top dut_i (
        .read        (read),
        .reset_reg_N (reset_reg_N),
        .addr        (addr),
        .wr_data     (wr_data),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .slot_sel    (slot_sel),
        .keys_on     (keys_on),
        .level_out   (level_out),
        .voice_free  (voice_free),
        .init_busy   (init_busy)
    );

    always #50 read = ~read;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic env_data_t env_setting(int env, int reg_sel);
        env_data_t v;
        case (reg_sel)
            0: v = (env == 3) ? 8'h01 : 8'h00;      // rate 1
            4: v = (env == 3) ? att_l1 : 8'h40;     // level 1
            5: v = 8'h30;
            6: v = sus_lvl;
            default: v = 8'h00;                     // other rates, level 4
        endcase
        return v;
    endfunction

    // round-robin slot scanner
    always @(posedge read) begin
        scan_cnt <= scan_cnt + 1'b1;
        slot_sel <= slot_t'(scan_cnt);
    end

    // delay line and bus model, sampled like the DUT
    always @(posedge read) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            stop_with_error("run did not finish within the cycle limit");
        end
        slot_d1 <= slot_sel;
        slot_d2 <= slot_d1;
        v_d1    <= reset_reg_N && !init_busy;
        v_d2    <= v_d1;
        key_d2  <= keys_on;
        busy_d  <= init_busy;
        if (reset_reg_N && init_busy) begin
            busy_cycles <= busy_cycles + 1;
        end
        if (rd_en) begin
            rd_exp <= shadow[addr];
        end
        if (wr_en && !addr[6]) begin
            shadow[addr] <= wr_data;
        end
        if (out_v0 && key_d2[0]) begin
            held_cnt[slot_d2.env] <= held_cnt[slot_d2.env] + 1'b1;
            if (slot_d2.env == 3) begin
                att_prev <= level_out;
            end
        end else if (out_v0 && held_cnt[slot_d2.env] != 0) begin
            rel_cnt[slot_d2.env] <= rel_cnt[slot_d2.env] + 1'b1;
        end
    end

    assign out_v0 = v_d2 && (slot_d2.voice == 0);

    a_rd_data: assert property (@(posedge read) disable iff (!reset_reg_N)
        rd_data == rd_exp)
        else stop_with_error($sformatf("Fail rd_data expected %h actual %h", rd_exp, rd_data));

    a_busy_len: assert property (@(posedge read) disable iff (!reset_reg_N)
        init_busy |-> (busy_cycles < 64))
        else stop_with_error("init sweep still busy after 64 cycles");

    a_sweep_level: assert property (@(posedge read) disable iff (!reset_reg_N)
        (init_busy || busy_d) |-> (level_out == 0))
        else stop_with_error($sformatf("Fail level_out expected 00 actual %h", level_out));

    a_sweep_free: assert property (@(posedge read) disable iff (!reset_reg_N)
        (init_busy || busy_d) |-> (voice_free == '1))
        else stop_with_error($sformatf("Fail voice_free expected ff actual %h", voice_free));

    // voices 1..7 are never keyed
    a_idle_voices: assert property (@(posedge read) disable iff (!reset_reg_N)
        voice_free[7:1] == 7'h7f)
        else stop_with_error($sformatf("Fail voice_free[7:1] expected 7f actual %h",
                                       voice_free[7:1]));

    // one visit per RATE and per LEVEL state up to level 3
    a_sustain: assert property (@(posedge read) disable iff (!reset_reg_N)
        (out_v0 && slot_d2.env == 1 && key_d2[0] && held_cnt[1] >= 5) |->
        (level_out == sus_lvl))
        else stop_with_error($sformatf("Fail level_out expected %h actual %h",
                                       sus_lvl, level_out));

    a_attack_range: assert property (@(posedge read) disable iff (!reset_reg_N)
        (out_v0 && slot_d2.env == 3 && key_d2[0] && held_cnt[3] >= 1) |->
        (level_out >= att_prev && level_out <= att_l1))
        else stop_with_error($sformatf("Fail level_out expected %h to %h actual %h",
                                       att_prev, att_l1, level_out));

    a_attack_moves: assert property (@(posedge read) disable iff (!reset_reg_N)
        (out_v0 && slot_d2.env == 3 && key_d2[0] && held_cnt[3] >= 8) |->
        (level_out != 0))
        else stop_with_error("stepped attack level never left zero");

    a_held_busy: assert property (@(posedge read) disable iff (!reset_reg_N)
        (held_cnt[1] != 0 && rel_cnt[1] == 0) |-> !voice_free[0])
        else stop_with_error($sformatf("Fail voice_free[0] expected 0 actual %h",
                                       voice_free[0]));

    // release visit enters RATE4, next one lands on level 4
    a_release_level: assert property (@(posedge read) disable iff (!reset_reg_N)
        (out_v0 && !key_d2[0] && rel_cnt[slot_d2.env] >= 1) |-> (level_out == 0))
        else stop_with_error($sformatf("Fail level_out expected 00 actual %h", level_out));

    a_release_free: assert property (@(posedge read) disable iff (!reset_reg_N)
        (rel_cnt[1] >= 3) |-> voice_free[0])
        else stop_with_error($sformatf("Fail voice_free[0] expected 1 actual %h",
                                       voice_free[0]));

    initial begin
        logic [7:0] a_rnd;
        logic [7:0] d_rnd;
        read        = 1'b0;
        reset_reg_N = 1'b0;
        addr        = '0;
        wr_data     = '0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        slot_sel    = '0;
        keys_on     = '0;
        for (int i = 0; i < 128; i++) begin
            shadow[i] = 8'h00;
        end
        for (int e = 0; e < 3; e++) begin
            shadow[e * 8 + 6] = `ENV_SUSTAIN_DEFAULT;   // level 3 is register 6
        end
        for (int e = 0; e < `ENV_ENVS; e++) begin
            held_cnt[e] = '0;
            rel_cnt[e]  = '0;
        end

        repeat (8) @(posedge read);
        reset_reg_N <= 1'b1;

        for (int a = 0; a < 64; a++) begin     // reset defaults, read during the sweep
            @(posedge read);
            addr  <= env_addr_t'(a);
            rd_en <= 1'b1;
        end
        wait (!init_busy);

        repeat (32) begin
            take_bits(6, a_rnd);
            take_bits(8, d_rnd);
            @(posedge read);
            addr    <= env_addr_t'(a_rnd[5:0]);
            wr_data <= d_rnd;
            rd_en   <= 1'b0;
            wr_en   <= 1'b1;
            @(posedge read);
            wr_en   <= 1'b0;
            rd_en   <= 1'b1;
        end
        @(posedge read);
        rd_en <= 1'b0;

        for (int a = 0; a < 64; a++) begin     // envelope settings for the scan
            @(posedge read);
            addr    <= env_addr_t'(a);
            wr_data <= env_setting(a / 8, a % 8);
            wr_en   <= 1'b1;
        end
        @(posedge read);
        wr_en <= 1'b0;
        @(posedge read);

        keys_on <= 8'h01;
        repeat (20 * 64) @(posedge read);
        keys_on <= 8'h00;
        repeat (8 * 64) @(posedge read);

        if (held_cnt[1] >= 6 && held_cnt[3] >= 9 && rel_cnt[1] >= 3) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_with_error("scan ended before every envelope check was reached");
        end
    end

endmodule

//--- env_gen.f
+incdir+verilog
verilog/env_regmap_pkg.sv
verilog/env_state_pkg.sv
verilog/env_param_regs.sv
verilog/env_state_ram.sv
verilog/env_core.sv
verilog/env_gen_top.sv
tests/env_gen_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wall -Wno-fatal
TOP      = env_gen_tb
FILELIST = env_gen.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failed
PASS_MSG = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -Wall -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
